// ==== hw/mulDiv_defs.svh ====
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// Operand and result width
`define MD_WIDTH 32

// Width of the multiplier operands and the divisor
`define MD_HALF 16

// One Booth iteration per multiplier bit
`define MUL_STEPS 16

// One restoring iteration per dividend bit
`define DIV_STEPS 32

// Must hold DIV_STEPS - 1
`define STEP_CNT_W 6

`endif

// ==== hw/mdDataPkg.sv ====
`include "mulDiv_defs.svh"

package mdDataPkg;

	typedef logic [`MD_WIDTH-1:0] word_t;
	typedef logic [`MD_HALF-1:0] half_t;

	typedef enum logic {
		MD_MUL = 1'b0,
		MD_DIV = 1'b1
	} mdOp_t;

	typedef struct packed {
		word_t opA;
		word_t opB;
	} mdOperands_t;

	// Exception is only meaningful for a divide
	typedef struct packed {
		word_t result;
		logic exception;
	} mdResp_t;

	typedef enum logic [1:0] {
		BOOTH_NOP = 2'd0,
		BOOTH_ADD = 2'd1,
		BOOTH_SUB = 2'd2
	} boothOp_t;

endpackage

// ==== hw/mdCtrlPkg.sv ====
`include "mulDiv_defs.svh"

package mdCtrlPkg;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,
		ST_DONE = 2'd2
	} mdState_t;

	typedef logic [`STEP_CNT_W-1:0] stepCnt_t;

	// load captures operands, step runs one iteration
	typedef struct packed {
		logic load;
		logic step;
	} mdStepCtl_t;

endpackage

// ==== hw/divSignCorrect.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module divSignCorrect import mdDataPkg::*; (
	input  logic  clock,
	input  logic  rstN,
	input  logic  load,
	input  word_t dividend,
	input  half_t divisor,
	input  word_t rawQuotient,
	output word_t absDividend,
	output half_t absDivisor,
	output word_t quotient,
	output logic  divByZero
);

	logic negateReg;
	logic zeroReg;

	// Most negative values map onto themselves, read as unsigned
	assign absDividend = dividend[`MD_WIDTH-1] ? -dividend : dividend;
	assign absDivisor = divisor[`MD_HALF-1] ? -divisor : divisor;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			negateReg <= 1'b0;
			zeroReg <= 1'b0;
		end else if (load) begin
			// Signs differ so the quotient is negative
			negateReg <= dividend[`MD_WIDTH-1] ^ divisor[`MD_HALF-1];
			zeroReg <= (divisor == '0);
		end
	end

	assign quotient = negateReg ? -rawQuotient : rawQuotient;
	assign divByZero = zeroReg;

endmodule

// ==== hw/restoringDivider.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module restoringDivider import mdDataPkg::*, mdCtrlPkg::*; (
	input  logic       clock,
	input  logic       rstN,
	input  mdStepCtl_t ctl,
	input  word_t      dividend,
	input  half_t      divisor,
	output word_t      quotient,
	output logic       divByZero
);

	word_t absDividend;
	half_t absDivisor;
	word_t remReg;
	word_t quoReg;
	half_t divisorReg;
	word_t remShift;
	word_t quoShift;
	logic [`MD_WIDTH:0] trial;

	divSignCorrect signCorrect (
		.clock      (clock),
		.rstN       (rstN),
		.load       (ctl.load),
		.dividend   (dividend),
		.divisor    (divisor),
		.rawQuotient(quoReg),
		.absDividend(absDividend),
		.absDivisor (absDivisor),
		.quotient   (quotient),
		.divByZero  (divByZero)
	);

	// Shift remainder and quotient left as one register
	assign remShift = {remReg[`MD_WIDTH-2:0], quoReg[`MD_WIDTH-1]};
	assign quoShift = {quoReg[`MD_WIDTH-2:0], 1'b0};

	// Extra top bit is the borrow of the trial subtraction
	assign trial = {1'b0, remShift} -
		{{(`MD_WIDTH-`MD_HALF+1){1'b0}}, divisorReg};

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			remReg <= '0;
			quoReg <= '0;
		end else if (ctl.load) begin
			remReg <= '0;
			quoReg <= absDividend;
		end else if (ctl.step) begin
			if (!trial[`MD_WIDTH]) begin
				remReg <= trial[`MD_WIDTH-1:0];
				quoReg <= quoShift | word_t'(1);
			end else begin
				// Restore, keep the shifted remainder
				remReg <= remShift;
				quoReg <= quoShift;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ctl.load) begin
			divisorReg <= absDivisor;
		end
	end

endmodule

// ==== hw/boothMultiplier.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module boothMultiplier import mdDataPkg::*, mdCtrlPkg::*; (
	input  logic       clock,
	input  logic       rstN,
	input  mdStepCtl_t ctl,
	input  half_t      multiplicand,
	input  half_t      multiplier,
	output word_t      product
);

	// Upper part is one bit wider than the multiplicand, so subtracting
	// the most negative value cannot overflow
	logic [2*`MD_HALF+1:0] acc;
	logic [2*`MD_HALF+1:0] accNext;
	logic [`MD_HALF:0] upperSum;
	logic [`MD_HALF:0] mcandExt;
	half_t mcandReg;
	boothOp_t boothOp;

	assign mcandExt = {mcandReg[`MD_HALF-1], mcandReg};

	// Current multiplier bit and the bit shifted out last time
	always_comb begin
		case (acc[1:0])
			2'b10: boothOp = BOOTH_SUB;
			2'b01: boothOp = BOOTH_ADD;
			default: boothOp = BOOTH_NOP;
		endcase
	end

	always_comb begin
		case (boothOp)
			BOOTH_ADD: upperSum = acc[2*`MD_HALF+1:`MD_HALF+1] + mcandExt;
			BOOTH_SUB: upperSum = acc[2*`MD_HALF+1:`MD_HALF+1] - mcandExt;
			default: upperSum = acc[2*`MD_HALF+1:`MD_HALF+1];
		endcase
	end

	// Arithmetic shift right after the add
	assign accNext = {upperSum[`MD_HALF], upperSum, acc[`MD_HALF:1]};

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			acc <= '0;
		end else if (ctl.load) begin
			acc <= {{(`MD_HALF+1){1'b0}}, multiplier, 1'b0};
		end else if (ctl.step) begin
			acc <= accNext;
		end
	end

	always_ff @(posedge clock) begin
		if (ctl.load) begin
			mcandReg <= multiplicand;
		end
	end

	// Product fits in 32 bits, the top accumulator bit is only a guard
	assign product = acc[2*`MD_HALF:1];

endmodule

// ==== hw/mulDivCtrl.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module mulDivCtrl import mdDataPkg::*, mdCtrlPkg::*; (
	input  logic       clock,
	input  logic       rstN,
	input  logic       startMul,
	input  logic       startDiv,
	input  word_t      product,
	input  word_t      quotient,
	input  logic       divByZero,
	output mdStepCtl_t mulCtl,
	output mdStepCtl_t divCtl,
	output logic       inputRdy,
	output logic       resultRdy,
	output mdResp_t    resp
);

	mdState_t state;
	mdOp_t opReg;
	stepCnt_t stepCnt;
	stepCnt_t lastStep;
	logic accept;
	logic running;

	assign inputRdy = (state == ST_IDLE);
	assign accept = inputRdy && (startMul || startDiv);
	assign running = (state == ST_RUN);

	// Multiply wins when both starts arrive together
	assign mulCtl.load = accept && startMul;
	assign divCtl.load = accept && !startMul;
	assign mulCtl.step = running && (opReg == MD_MUL);
	assign divCtl.step = running && (opReg == MD_DIV);

	assign lastStep = (opReg == MD_MUL) ? stepCnt_t'(`MUL_STEPS - 1) :
		stepCnt_t'(`DIV_STEPS - 1);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= ST_IDLE;
			opReg <= MD_MUL;
			stepCnt <= '0;
			resultRdy <= 1'b0;
			resp <= '0;
		end else begin
			// One-cycle pulse unless DONE sets it below
			resultRdy <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						opReg <= startMul ? MD_MUL : MD_DIV;
						stepCnt <= '0;
						state <= ST_RUN;
					end
				end
				ST_RUN: begin
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == lastStep) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					// Datapath outputs are settled by now
					resp.result <= (opReg == MD_MUL) ? product : quotient;
					resp.exception <= (opReg == MD_DIV) && divByZero;
					resultRdy <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hw/mulDivTop.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module mulDivTop import mdDataPkg::*, mdCtrlPkg::*; (
	input  logic        clock,
	input  logic        rstN,
	input  mdOperands_t operands,
	input  logic        startMul,
	input  logic        startDiv,
	output logic        inputRdy,
	output logic        resultRdy,
	output mdResp_t     resp
);

	mdStepCtl_t mulCtl;
	mdStepCtl_t divCtl;
	word_t product;
	word_t quotient;
	logic divByZero;

	mulDivCtrl ctrl (
		.clock    (clock),
		.rstN     (rstN),
		.startMul (startMul),
		.startDiv (startDiv),
		.product  (product),
		.quotient (quotient),
		.divByZero(divByZero),
		.mulCtl   (mulCtl),
		.divCtl   (divCtl),
		.inputRdy (inputRdy),
		.resultRdy(resultRdy),
		.resp     (resp)
	);

	// Multiply uses only the low halves of both operands
	boothMultiplier mul (
		.clock       (clock),
		.rstN        (rstN),
		.ctl         (mulCtl),
		.multiplicand(operands.opA[`MD_HALF-1:0]),
		.multiplier  (operands.opB[`MD_HALF-1:0]),
		.product     (product)
	);

	restoringDivider div (
		.clock    (clock),
		.rstN     (rstN),
		.ctl      (divCtl),
		.dividend (operands.opA),
		.divisor  (operands.opB[`MD_HALF-1:0]),
		.quotient (quotient),
		.divByZero(divByZero)
	);

endmodule

// ==== dv/mulDivTb.sv ====
`timescale 1ns/1ps

`include "mulDiv_defs.svh"

module mulDivTb import mdDataPkg::*; ();

	localparam int NUM_DIRECTED = 12;
	localparam int NUM_RANDOM = 120;
	localparam int NUM_TESTS = NUM_DIRECTED + NUM_RANDOM;
	// Longest operation plus a spare cycle for each test
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 35 + 100;

	logic clock;
	logic rstN;
	mdOperands_t operands;
	logic startMul;
	logic startDiv;
	logic inputRdy;
	logic resultRdy;
	mdResp_t resp;

	logic [31:0] lfsrState = 32'd13964;
	int cycleCount = 0;
	int checkCount = 0;
	int productErrors = 0;
	int quotientErrors = 0;
	int exceptionErrors = 0;
	int handshakeErrors = 0;
	int latencyErrors = 0;

	mulDivTop dut (
		.clock    (clock),
		.rstN     (rstN),
		.operands (operands),
		.startMul (startMul),
		.startDiv (startDiv),
		.inputRdy (inputRdy),
		.resultRdy(resultRdy),
		.resp     (resp)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles, resultRdy never came",
				TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic nextLfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return outBit;
	endfunction

	function automatic word_t drawBits(input int count);
		word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[`MD_WIDTH-2:0], nextLfsrBit()};
		end
		return value;
	endfunction

	// One draw in four is a corner value
	function automatic word_t drawOperand();
		logic [1:0] sel;
		logic [1:0] pick;
		word_t value;
		sel = 2'(drawBits(2));
		if (sel == 2'b00) begin
			pick = 2'(drawBits(2));
			case (pick)
				2'd0: value = 32'h0000_0000;
				2'd1: value = 32'hFFFF_FFFF;
				2'd2: value = 32'h8000_0000;
				default: value = 32'hFFFF_8000;
			endcase
		end else begin
			value = drawBits(32);
		end
		return value;
	endfunction

	// Signed 16x16 product of the low halves
	function automatic word_t modelProduct(input word_t a, input word_t b);
		logic signed [`MD_HALF-1:0] x;
		logic signed [`MD_HALF-1:0] y;
		logic signed [`MD_WIDTH-1:0] p;
		x = a[`MD_HALF-1:0];
		y = b[`MD_HALF-1:0];
		p = x * y;
		return word_t'(p);
	endfunction

	// Wide signed divide truncates toward zero and the low word is kept
	function automatic word_t modelQuotient(input word_t a, input word_t b);
		logic signed [`MD_HALF-1:0] dh;
		logic signed [63:0] n;
		logic signed [63:0] d;
		logic signed [63:0] q;
		dh = b[`MD_HALF-1:0];
		n = $signed(a);
		d = dh;
		q = n / d;
		return q[`MD_WIDTH-1:0];
	endfunction

	task automatic checkProduct(input word_t expected, input word_t actual);
		checkCount++;
		if (actual !== expected) begin
			productErrors++;
			$display("[ERROR] %0t: resp.result (product) expected %h, got %h",
				$time, expected, actual);
		end
	endtask

	task automatic checkQuotient(input word_t expected, input word_t actual);
		checkCount++;
		if (actual !== expected) begin
			quotientErrors++;
			$display("[ERROR] %0t: resp.result (quotient) expected %h, got %h",
				$time, expected, actual);
		end
	endtask

	task automatic checkException(input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			exceptionErrors++;
			$display("[ERROR] %0t: resp.exception expected %b, got %b",
				$time, expected, actual);
		end
	endtask

	task automatic checkHandshake(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			handshakeErrors++;
			$display("[ERROR] %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// Called on a falling edge with the unit idle and returns in the resultRdy cycle
	task automatic runOp(input mdOp_t op, input word_t a, input word_t b,
		input logic interfere);
		int edges;
		int expEdges;
		word_t expResult;
		logic expExc;
		expEdges = (op == MD_MUL) ? `MUL_STEPS + 1 : `DIV_STEPS + 1;
		expExc = (op == MD_DIV) && (b[`MD_HALF-1:0] == '0);
		if (op == MD_MUL) begin
			expResult = modelProduct(a, b);
		end else if (!expExc) begin
			expResult = modelQuotient(a, b);
		end else begin
			expResult = '0;
		end
		checkHandshake("inputRdy", 1'b1, inputRdy);
		operands.opA = a;
		operands.opB = b;
		startMul = (op == MD_MUL);
		startDiv = (op == MD_DIV);
		@(posedge clock);
		@(negedge clock);
		startMul = 1'b0;
		startDiv = 1'b0;
		// Operands must not matter once loaded
		operands = {drawBits(32), drawBits(32)};
		checkHandshake("inputRdy", 1'b0, inputRdy);
		edges = 0;
		while (!resultRdy) begin
			if (interfere && edges == 3) begin
				startMul = (op == MD_DIV);
				startDiv = (op == MD_MUL);
			end else begin
				startMul = 1'b0;
				startDiv = 1'b0;
			end
			@(posedge clock);
			edges++;
			@(negedge clock);
		end
		if (edges != expEdges) begin
			latencyErrors++;
			$display("[ERROR] %0t: resultRdy latency expected %0d edges, got %0d",
				$time, expEdges, edges);
		end
		checkHandshake("inputRdy", 1'b1, inputRdy);
		if (op == MD_MUL) begin
			checkProduct(expResult, resp.result);
		end else if (!expExc) begin
			checkQuotient(expResult, resp.result);
		end
		checkException(expExc, resp.exception);
		if (interfere) begin
			// Single pulse and resp holds while idle
			repeat (3) begin
				@(posedge clock);
				@(negedge clock);
				checkHandshake("resultRdy", 1'b0, resultRdy);
				if (op == MD_MUL) begin
					checkProduct(expResult, resp.result);
				end else if (!expExc) begin
					checkQuotient(expResult, resp.result);
				end
			end
		end
	endtask

	initial begin
		int totalErrors;
		logic pickDiv;
		rstN = 1'b0;
		startMul = 1'b0;
		startDiv = 1'b0;
		operands = '0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		@(negedge clock);
		checkHandshake("inputRdy", 1'b1, inputRdy);
		checkHandshake("resultRdy", 1'b0, resultRdy);
		checkProduct('0, resp.result);
		checkException(1'b0, resp.exception);

		runOp(MD_MUL, 32'h0000_8000, 32'h0000_8000, 1'b0);
		runOp(MD_MUL, word_t'(-3), 32'h0000_7FFF, 1'b0);
		// All four sign combinations
		runOp(MD_DIV, word_t'(100), word_t'(7), 1'b0);
		runOp(MD_DIV, word_t'(-100), word_t'(7), 1'b0);
		runOp(MD_DIV, word_t'(100), word_t'(-7), 1'b0);
		runOp(MD_DIV, word_t'(-100), word_t'(-7), 1'b0);
		runOp(MD_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
		runOp(MD_DIV, 32'h8000_0000, 32'h0000_8000, 1'b0);
		// Divisor low half is zero and the upper half is ignored
		runOp(MD_DIV, 32'h0000_1234, 32'h0000_0000, 1'b0);
		runOp(MD_DIV, word_t'(-5), 32'h1234_0000, 1'b0);
		runOp(MD_MUL, word_t'(-1234), word_t'(567), 1'b1);
		runOp(MD_DIV, word_t'(-98765), word_t'(321), 1'b1);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			pickDiv = nextLfsrBit();
			if (pickDiv) begin
				runOp(MD_DIV, drawOperand(), drawOperand(), 1'b0);
			end else begin
				runOp(MD_MUL, drawOperand(), drawOperand(), 1'b0);
			end
		end

		totalErrors = productErrors + quotientErrors + exceptionErrors +
			handshakeErrors + latencyErrors;
		$display("Checks %0d errors: mul %0d div %0d exc %0d handshake %0d latency %0d",
			checkCount, productErrors, quotientErrors, exceptionErrors,
			handshakeErrors, latencyErrors);
		if (totalErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hw
hw/mdDataPkg.sv
hw/mdCtrlPkg.sv
hw/divSignCorrect.sv
hw/restoringDivider.sv
hw/boothMultiplier.sv
hw/mulDivCtrl.sv
hw/mulDivTop.sv
dv/mulDivTb.sv
